// ==== verilog/mul_data_pkg.sv ====
package mul_data_pkg;

    //////////////////////////////////////////////////////////////////////
    // datapath widths
    //////////////////////////////////////////////////////////////////////

    // each operand, unsigned
    localparam int op_width    = 64;
    // full product, a*b fits without overflow
    localparam int prod_width  = 128;

    // radix-4 digits of the zero-extended multiplier
    // also the height of every product column
    localparam int n_rows      = 33;
    // carries handed from one column to the next
    localparam int n_col_carry = 30;

    // width of one carry-propagate step
    localparam int slice_width = 32;

endpackage

// ==== verilog/mul_ctrl_pkg.sv ====
package mul_ctrl_pkg;

    //////////////////////////////////////////////////////////////////////
    // sequencer constants
    //////////////////////////////////////////////////////////////////////

    // adder steps per product
    localparam int n_slices        = 4;
    // counter width, enough for n_slices
    localparam int slice_idx_width = 2;

    // sequencer states
    typedef enum logic [1:0] {
        st_idle     = 2'd0,
        st_compress = 2'd1,
        st_add      = 2'd2,
        st_done     = 2'd3
    } mul_state_t;

endpackage

// ==== verilog/booth_rows.sv ====
`timescale 1ns/1ps

module booth_rows import mul_data_pkg::*; (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 load,
    input  logic [op_width-1:0]                  a,
    input  logic [op_width-1:0]                  b,
    output logic [n_rows-1:0][prod_width-1:0]    rows
);

    // operand registers
    logic [op_width-1:0] a_q;
    logic [op_width-1:0] b_q;
    // multiplier with implicit zero below and two zero bits on top
    logic [op_width+2:0] b_ext;
    // per-digit decode
    logic [n_rows-1:0]   dig_one;
    logic [n_rows-1:0]   dig_two;
    logic [n_rows-1:0]   dig_neg;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            a_q <= '0;
            b_q <= '0;
        end else if (load) begin
            a_q <= a;
            b_q <= b;
        end
    end

    assign b_ext = {2'b00, b_q, 1'b0};

    //////////////////////////////////////////////////////////////////////
    // digit decode and row select
    //////////////////////////////////////////////////////////////////////

    for (genvar g = 0; g < n_rows; g++) begin : g_row
        logic [2:0]            trip;
        logic [prod_width-1:0] mag;
        logic [prod_width-1:0] mag_sh;

        // overlapping triplet of bits 2g+1 .. 2g-1 of b
        assign trip = b_ext[2*g +: 3];

        // +-1 for 001 010 101 110
        assign dig_one[g] = trip[0] ^ trip[1];
        // +-2 for 011 and 100
        assign dig_two[g] = (trip == 3'b011) | (trip == 3'b100);
        // negative for 1xx except 111 which is zero
        assign dig_neg[g] = trip[2] & ~(trip[1] & trip[0]);

        // magnitude a or 2a zero-extended
        assign mag = dig_one[g] ? {{(prod_width-op_width){1'b0}}, a_q} :
                     dig_two[g] ? {{(prod_width-op_width-1){1'b0}}, a_q, 1'b0} :
                                  '0;
        // weight 4^g
        assign mag_sh = mag << (2*g);

        // full two's complement negate wrapping mod 2^128
        assign rows[g] = dig_neg[g] ? -mag_sh : mag_sh;

        // decode must give -2*b[2g+1] + b[2g] + b[2g-1]
        a_digit_value: assert property (@(posedge clk) disable iff (!rst_n)
            $onehot0({dig_one[g], dig_two[g]}) &&
            ((dig_neg[g] ? -int'({dig_two[g], dig_one[g]}) : int'({dig_two[g], dig_one[g]}))
                == int'(trip[1]) + int'(trip[0]) - 2 * int'(trip[2])));
    end

endmodule

// ==== verilog/wallace_33bit.sv ====
`timescale 1ns/1ps

module wallace_33bit (
    input  logic [32:0] N,
    input  logic [29:0] Ci,
    output logic [29:0] Cout,
    output logic        S,
    output logic        C
);

    // partial sums inside the column
    logic [29:0] Si;

    // 3:2 cell, returns {carry, sum}
    function automatic logic [1:0] fa(input logic [2:0] x);
        fa = {(x[0] & x[1]) | (x[0] & x[2]) | (x[1] & x[2]), ^x};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // level 1, eleven cells on the raw column bits
    //////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < 11; i++) begin : g_lvl1
        assign {Cout[i], Si[i]} = fa(N[i*3 +: 3]);
    end

    // level 2, first incoming carries join here
    assign {Cout[11], Si[11]} = fa(Si[2:0]);
    assign {Cout[12], Si[12]} = fa(Si[5:3]);
    assign {Cout[13], Si[13]} = fa(Si[8:6]);
    assign {Cout[14], Si[14]} = fa({Si[10:9], Ci[0]});
    assign {Cout[15], Si[15]} = fa(Ci[3:1]);
    assign {Cout[16], Si[16]} = fa(Ci[6:4]);
    assign {Cout[17], Si[17]} = fa(Ci[9:7]);

    // level 3
    assign {Cout[18], Si[18]} = fa(Si[13:11]);
    assign {Cout[19], Si[19]} = fa(Si[16:14]);
    assign {Cout[20], Si[20]} = fa({Si[17], Ci[11:10]});
    assign {Cout[21], Si[21]} = fa(Ci[14:12]);
    assign {Cout[22], Si[22]} = fa(Ci[17:15]);

    // level 4
    assign {Cout[23], Si[23]} = fa(Si[20:18]);
    assign {Cout[24], Si[24]} = fa({Si[22:21], Ci[18]});
    assign {Cout[25], Si[25]} = fa(Ci[21:19]);

    // level 5
    assign {Cout[26], Si[26]} = fa(Si[25:23]);
    assign {Cout[27], Si[27]} = fa(Ci[24:22]);

    // levels 6 and 7, late carries of the lower column arrive here
    assign {Cout[28], Si[28]} = fa({Si[27:26], Ci[25]});
    assign {Cout[29], Si[29]} = fa({Si[28], Ci[27:26]});

    // last cell, two bits left for the final adder
    assign {C, S} = fa({Si[29], Ci[29:28]});

endmodule

// ==== verilog/csa_array.sv ====
`timescale 1ns/1ps

module csa_array import mul_data_pkg::*; (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              capture,
    input  logic [n_rows-1:0][prod_width-1:0] rows,
    output logic [prod_width-1:0]             sum_vec,
    output logic [prod_width-1:0]             carry_vec
);

    // column k holds bit k of every row
    logic [n_rows-1:0]      col_bits [prod_width];
    // carries into and out of each column
    logic [n_col_carry-1:0] col_ci   [prod_width];
    logic [n_col_carry-1:0] col_co   [prod_width];
    // two bits left per column
    logic [prod_width-1:0]  col_s;
    logic [prod_width-1:0]  col_c;

    //////////////////////////////////////////////////////////////////////
    // column compressors
    //////////////////////////////////////////////////////////////////////

    for (genvar k = 0; k < prod_width; k++) begin : g_col
        // transpose
        for (genvar r = 0; r < n_rows; r++) begin : g_bit
            assign col_bits[k][r] = rows[r][k];
        end

        // ripple between columns, bottom column sees none
        // carries out of the top column fall off, product is mod 2^128
        if (k == 0) begin : g_first
            assign col_ci[k] = '0;
        end else begin : g_next
            assign col_ci[k] = col_co[k-1];
        end

        wallace_33bit col_inst (
            .N    (col_bits[k]),
            .Ci   (col_ci[k]),
            .Cout (col_co[k]),
            .S    (col_s[k]),
            .C    (col_c[k])
        );
    end

    // hold both vectors for the slice adder
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sum_vec   <= '0;
            carry_vec <= '0;
        end else if (capture) begin
            sum_vec   <= col_s;
            carry_vec <= col_c;
        end
    end

endmodule

// ==== verilog/slice_adder.sv ====
`timescale 1ns/1ps

module slice_adder import mul_data_pkg::*, mul_ctrl_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       clear,
    input  logic                       step,
    input  logic [slice_idx_width-1:0] idx,
    input  logic [prod_width-1:0]      sum_vec,
    input  logic [prod_width-1:0]      carry_vec,
    output logic [prod_width-1:0]      product
);

    // carry vector at its true weight
    logic [prod_width-1:0]  carry_sh;
    // operands of the current step
    logic [slice_width-1:0] sum_sl;
    logic [slice_width-1:0] carry_sl;
    // one extra bit for the carry out
    logic [slice_width:0]   step_res;
    // carry between steps
    logic                   cy_q;

    // column C bits weigh one more than their column
    assign carry_sh = {carry_vec[prod_width-2:0], 1'b0};

    assign sum_sl   = sum_vec[idx*slice_width +: slice_width];
    assign carry_sl = carry_sh[idx*slice_width +: slice_width];

    assign step_res = {1'b0, sum_sl} + {1'b0, carry_sl} + {{slice_width{1'b0}}, cy_q};

    //////////////////////////////////////////////////////////////////////
    // carry register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cy_q <= 1'b0;
        end else if (clear) begin
            cy_q <= 1'b0;
        end else if (step) begin
            cy_q <= step_res[slice_width];
        end
    end

    // product slices, each written once per operation
    always_ff @(posedge clk) begin
        if (step) begin
            product[idx*slice_width +: slice_width] <= step_res[slice_width-1:0];
        end
    end

    // clear and step come from different states
    a_no_step_clear: assert property (@(posedge clk) disable iff (!rst_n)
        !(step && clear));

endmodule

// ==== verilog/slice_counter.sv ====
`timescale 1ns/1ps

module slice_counter import mul_ctrl_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       clear,
    input  logic                       step,
    output logic [slice_idx_width-1:0] idx,
    output logic                       last
);

    // index of the final slice
    localparam logic [slice_idx_width-1:0] idx_last = slice_idx_width'(n_slices - 1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            idx <= '0;
        end else if (clear) begin
            idx <= '0;
        end else if (step && idx != idx_last) begin
            // stops at the top, no wrap
            idx <= idx + 1'b1;
        end
    end

    assign last = (idx == idx_last);

    // the top slice takes exactly one step, then stepping stops
    a_single_last_step: assert property (@(posedge clk) disable iff (!rst_n)
        (step && last) |=> !step);

endmodule

// ==== verilog/mul_fsm.sv ====
`timescale 1ns/1ps

module mul_fsm import mul_ctrl_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic req,
    input  logic last,
    output logic ack,
    output logic load,
    output logic capture,
    output logic step,
    output logic clear
);

    mul_state_t state;
    mul_state_t state_nxt;

    //////////////////////////////////////////////////////////////////////
    // state register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            // wait for a request
            st_idle:     if (req) state_nxt = st_compress;
            // tree settles and vectors latch at the end
            st_compress: state_nxt = st_add;
            // one slice per cycle
            st_add:      if (last) state_nxt = st_done;
            // hold result until requester lets go
            st_done:     if (!req) state_nxt = st_idle;
            default:     state_nxt = st_idle;
        endcase
    end

    // decoded outputs
    assign load    = (state == st_idle) && req;
    assign capture = (state == st_compress);
    assign clear   = (state == st_compress);
    assign step    = (state == st_add);
    assign ack     = (state == st_done);

    // ack only answers a request still held
    a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past(req));

    // a load reaches the top slice after n_slices steps and then acks
    a_load_sequence: assert property (@(posedge clk) disable iff (!rst_n)
        load |-> ##(n_slices + 1) (step && last) ##1 ack);

endmodule

// ==== verilog/mul_top.sv ====
`timescale 1ns/1ps

module mul_top import mul_data_pkg::*, mul_ctrl_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req,
    input  logic [op_width-1:0]   a,
    input  logic [op_width-1:0]   b,
    output logic                  ack,
    output logic [prod_width-1:0] product
);

    // sequencer strobes
    logic                              load;
    logic                              capture;
    logic                              step;
    logic                              clear;
    logic                              last;
    logic [slice_idx_width-1:0]        idx;
    // datapath
    logic [n_rows-1:0][prod_width-1:0] rows;
    logic [prod_width-1:0]             sum_vec;
    logic [prod_width-1:0]             carry_vec;

    mul_fsm mul_fsm_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .last    (last),
        .ack     (ack),
        .load    (load),
        .capture (capture),
        .step    (step),
        .clear   (clear)
    );

    slice_counter slice_counter_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (clear),
        .step  (step),
        .idx   (idx),
        .last  (last)
    );

    booth_rows booth_rows_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (load),
        .a     (a),
        .b     (b),
        .rows  (rows)
    );

    csa_array csa_array_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .capture   (capture),
        .rows      (rows),
        .sum_vec   (sum_vec),
        .carry_vec (carry_vec)
    );

    slice_adder slice_adder_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .clear     (clear),
        .step      (step),
        .idx       (idx),
        .sum_vec   (sum_vec),
        .carry_vec (carry_vec),
        .product   (product)
    );

endmodule

// ==== test/mul_checker.sv ====
`timescale 1ns/1ps

module mul_checker import mul_data_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req,
    input  logic                  ack,
    input  logic [prod_width-1:0] product,
    output int                    n_done,
    output int                    n_pass,
    output int                    n_fail
);

    localparam int max_tests   = 64;
    localparam int rec_width   = 2*op_width + prod_width;
    // edges from the req sampling edge to ack
    localparam int ack_latency = 5;

    typedef enum logic [1:0] {ph_idle, ph_busy, ph_ack} phase_t;

    logic [rec_width-1:0]  pattern_mem [max_tests];
    logic [prod_width-1:0] exp_product;
    logic [prod_width-1:0] held_product;
    phase_t                phase;
    int                    lat;
    int                    req_low_edges;
    bit                    test_bad;

    initial begin
        $readmemh("test/mul_patterns.hex", pattern_mem);
    end

    task automatic flag_error(input string msg);
        $display("%s", msg);
        test_bad = 1'b1;
    endtask

    //////////////////////////////////////////////////////////////////////
    // handshake and product watch
    //////////////////////////////////////////////////////////////////////

    // DUT outputs move on the rising edge, stable here
    always @(negedge clk) begin
        if (!rst_n) begin
            phase  = ph_idle;
            n_done = 0;
            n_pass = 0;
            n_fail = 0;
        end else begin
            case (phase)
                ph_idle: begin
                    if (ack !== 1'b0) begin
                        $display("ack is high while no request is outstanding");
                        n_fail++;
                    end
                end
                ph_busy: begin
                    if (ack === 1'b1) begin
                        if (lat != ack_latency) begin
                            flag_error($sformatf("ack rose %0d edges after req in test %0d",
                                                 lat, n_done));
                        end
                        exp_product = pattern_mem[n_done][prod_width-1:0];
                        if (product !== exp_product) begin
                            flag_error($sformatf("mismatch product exp=%h got=%h in test %0d",
                                                 exp_product, product, n_done));
                        end
                        held_product  = product;
                        // req may already be gone on the ack edge
                        req_low_edges = req ? 0 : 1;
                        phase         = ph_ack;
                    end else begin
                        lat++;
                    end
                end
                ph_ack: begin
                    if (ack === 1'b1) begin
                        if (product !== held_product) begin
                            flag_error($sformatf("product changed under ack in test %0d",
                                                 n_done));
                            held_product = product;
                        end
                        if (!req) begin
                            req_low_edges++;
                        end
                    end else begin
                        // ack should drop on the first edge that sees req low
                        if (req_low_edges != 1) begin
                            flag_error($sformatf("ack fell %0d edges after req in test %0d",
                                                 req_low_edges, n_done));
                        end
                        if (test_bad) begin
                            $display("test %0d failed", n_done);
                            n_fail++;
                        end else begin
                            $display("test %0d passed a=%h b=%h", n_done,
                                     pattern_mem[n_done][rec_width-1 -: op_width],
                                     pattern_mem[n_done][prod_width +: op_width]);
                            n_pass++;
                        end
                        n_done++;
                        phase = ph_idle;
                    end
                end
                default: phase = ph_idle;
            endcase

            // next rising edge samples this request
            if (phase == ph_idle && ack === 1'b0 && req === 1'b1) begin
                phase    = ph_busy;
                lat      = 0;
                test_bad = 1'b0;
            end
        end
    end

endmodule

// ==== test/tb_mul_top.sv ====
`timescale 1ns/1ps

module tb_mul_top import mul_data_pkg::*; ();

    localparam int  max_tests    = 64;
    localparam int  rec_width    = 2*op_width + prod_width;
    localparam int  reset_cycles = 10;
    localparam int  idle_cycles  = 10;
    localparam int  ack_timeout  = 50;
    localparam int  drain_cycles = 10;
    localparam time drive_delay  = 1ns;

    logic                  clk;
    logic                  rst_n;
    logic                  req;
    logic [op_width-1:0]   a;
    logic [op_width-1:0]   b;
    logic                  ack;
    logic [prod_width-1:0] product;

    // one record per test, {a, b, expected product}
    logic [rec_width-1:0]  pattern_mem [max_tests];
    integer                seed;
    int                    n_tests;
    bit                    timed_out;
    // running totals from the checker
    int                    n_done;
    int                    n_pass;
    int                    n_fail;

    mul_top mul_top_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .a       (a),
        .b       (b),
        .ack     (ack),
        .product (product)
    );

    mul_checker checker_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .ack     (ack),
        .product (product),
        .n_done  (n_done),
        .n_pass  (n_pass),
        .n_fail  (n_fail)
    );

    // 10 ns clock
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // drive helpers
    //////////////////////////////////////////////////////////////////////

    // inputs change just after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #drive_delay;
    endtask

    task automatic wait_for_ack(input logic level, input int test_no, output bit ok);
        ok = 1'b0;
        for (int i = 0; i < ack_timeout; i++) begin
            next_cycle();
            if (ack === level) begin
                ok = 1'b1;
                break;
            end
        end
        if (!ok) begin
            $display("timeout waiting for ack to %s in test %0d",
                     level ? "rise" : "fall", test_no);
        end
    endtask

    // one full four-phase transfer
    task automatic run_test(input int test_no, output bit ok);
        logic [rec_width-1:0] rec;
        int                   n_hold;
        rec = pattern_mem[test_no];
        a   = rec[rec_width-1 -: op_width];
        b   = rec[prod_width +: op_width];
        req = 1'b1;
        // sampling edge, operands are latched here
        next_cycle();
        // junk on the bus, must not reach the product
        a = {$random(seed), $random(seed)};
        b = {$random(seed), $random(seed)};
        wait_for_ack(1'b1, test_no, ok);
        if (!ok) begin
            return;
        end
        // back-pressure, 0 to 3 extra cycles
        n_hold = $unsigned($random(seed)) % 4;
        repeat (n_hold) next_cycle();
        req = 1'b0;
        wait_for_ack(1'b0, test_no, ok);
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin : main_seq
        bit ok;
        seed      = 6844;
        rst_n     = 1'b0;
        req       = 1'b0;
        a         = '0;
        b         = '0;
        timed_out = 1'b0;
        $readmemh("test/mul_patterns.hex", pattern_mem);
        // records end at the first unloaded entry
        n_tests = 0;
        while (n_tests < max_tests && !$isunknown(pattern_mem[n_tests])) begin
            n_tests++;
        end

        repeat (reset_cycles) next_cycle();
        rst_n = 1'b1;
        // quiet stretch, ack must stay low
        repeat (idle_cycles) next_cycle();

        for (int t = 0; t < n_tests; t++) begin
            run_test(t, ok);
            if (!ok) begin
                timed_out = 1'b1;
                break;
            end
        end

        // checker closes the last test one half cycle later
        if (!timed_out) begin
            ok = 1'b0;
            for (int i = 0; i < drain_cycles; i++) begin
                next_cycle();
                if (n_done == n_tests) begin
                    ok = 1'b1;
                    break;
                end
            end
            if (!ok) begin
                $display("timeout waiting for the checker to close test %0d", n_done);
                timed_out = 1'b1;
            end
        end

        $display("tests run=%0d passed=%0d failed=%0d", n_done, n_pass, n_fail);
        if (timed_out || n_fail != 0 || n_done != n_tests || n_tests == 0) begin
            $display("Simulation finished: FAIL");
        end else begin
            $display("Simulation finished: PASS");
        end
        $finish;
    end

endmodule

// ==== test/mul_patterns.hex ====
// one test per line in hex
// operand a _ operand b _ expected product (128 bit)
0000000000000000_0000000000000000_00000000000000000000000000000000
0000000000000000_123456789abcdef0_00000000000000000000000000000000
fedcba9876543210_0000000000000000_00000000000000000000000000000000
0000000000000001_123456789abcdef0_0000000000000000123456789abcdef0
fedcba9876543210_0000000000000001_0000000000000000fedcba9876543210
ffffffffffffffff_ffffffffffffffff_fffffffffffffffe0000000000000001
0000000000000001_0000000000000001_00000000000000000000000000000001
ffffffffffffffff_aaaaaaaaaaaaaaaa_aaaaaaaaaaaaaaa95555555555555556
5555555555555555_ffffffffffffffff_5555555555555554aaaaaaaaaaaaaaab
aaaaaaaaaaaaaaaa_5555555555555555_38e38e38e38e38e31c71c71c71c71c72
5555555555555555_5555555555555555_1c71c71c71c71c718e38e38e38e38e39
aaaaaaaaaaaaaaaa_aaaaaaaaaaaaaaaa_71c71c71c71c71c638e38e38e38e38e4
8000000000000000_8000000000000000_40000000000000000000000000000000
8000000000000000_ffffffffffffffff_7fffffffffffffff8000000000000000
00000000ffffffff_00000000ffffffff_0000000000000000fffffffe00000001
0000000100000001_0000000100000001_00000000000000010000000200000001
123456789abcdef0_0000000000000010_000000000000000123456789abcdef00
fffffffffffffffe_ffffffffffffffff_fffffffffffffffd0000000000000002

// ==== sources.f ====
verilog/mul_data_pkg.sv
verilog/mul_ctrl_pkg.sv
verilog/booth_rows.sv
verilog/wallace_33bit.sv
verilog/csa_array.sv
verilog/slice_adder.sv
verilog/slice_counter.sv
verilog/mul_fsm.sv
verilog/mul_top.sv
test/mul_checker.sv
test/tb_mul_top.sv

// ==== Bender.yml ====
package:
  name: mul64_wallace

sources:
  - verilog/mul_data_pkg.sv
  - verilog/mul_ctrl_pkg.sv
  - verilog/booth_rows.sv
  - verilog/wallace_33bit.sv
  - verilog/csa_array.sv
  - verilog/slice_adder.sv
  - verilog/slice_counter.sv
  - verilog/mul_fsm.sv
  - verilog/mul_top.sv
  - target: test
    files:
      - test/mul_checker.sv
      - test/tb_mul_top.sv
